// ==== verilog/exec_params.svh ====
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// Data and address width of the integer datapath.
`define EXEC_XLEN 32

// The restoring divider retires one quotient bit per iteration.
`define EXEC_DIV_STEPS `EXEC_XLEN

`endif

// ==== verilog/exec_pkg.sv ====
package exec_pkg;

  `include "exec_params.svh"

  typedef enum logic [1:0] {
    UNIT_ALU,
    UNIT_BRANCH,
    UNIT_DIV
  } unit_t;

  typedef enum logic [3:0] {
    FN_ADD,
    FN_SUB,
    FN_AND,
    FN_OR,
    FN_XOR,
    FN_SLL,
    FN_SRL,
    FN_SLT,
    FN_SLTU
  } alu_fn_t;

  typedef enum logic [3:0] {
    FN_BEQ,
    FN_BNE,
    FN_BLT,
    FN_BGE,
    FN_BLTU,
    FN_BGEU
  } branch_fn_t;

  typedef enum logic [3:0] {
    FN_DIVU,
    FN_REMU
  } div_fn_t;

  // The same function code, read through the member picked by the unit field.
  typedef union packed {
    alu_fn_t    alu;
    branch_fn_t branch;
    div_fn_t    div;
  } fn_u;

  typedef struct packed {
    logic                  valid;
    unit_t                 unit;
    fn_u                   fn;
    logic [`EXEC_XLEN-1:0] rdata1;
    logic [`EXEC_XLEN-1:0] rdata2;
    logic [`EXEC_XLEN-1:0] imm;
    logic                  sel_imm;
    logic [`EXEC_XLEN-1:0] pc;
    logic [4:0]            rd;
  } execute_in_t;

  typedef struct packed {
    logic                  valid;
    logic [4:0]            rd;
    logic [`EXEC_XLEN-1:0] wdata;
    logic                  taken;
    logic [`EXEC_XLEN-1:0] target;
  } execute_out_t;

  typedef struct packed {
    logic [`EXEC_XLEN-1:0] result;
    logic                  taken;
    logic [`EXEC_XLEN-1:0] target;
  } alu_result_t;

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_BUSY,
    DIV_DONE
  } div_state_t;

endpackage

// ==== verilog/exec_alu.sv ====
`include "exec_params.svh"

module exec_alu import exec_pkg::*; (
  input  execute_in_t in,
  output alu_result_t out
);

  localparam int SHW = $clog2(`EXEC_XLEN);

  logic [`EXEC_XLEN-1:0] op2;
  logic [`EXEC_XLEN-1:0] value;
  logic [SHW-1:0]        shamt;
  logic                  cond;

  always_comb begin
    op2 = in.sel_imm ? in.imm : in.rdata2;
    shamt = op2[SHW-1:0];

    case (in.fn.alu)
      FN_ADD:  value = in.rdata1 + op2;
      FN_SUB:  value = in.rdata1 - op2;
      FN_AND:  value = in.rdata1 & op2;
      FN_OR:   value = in.rdata1 | op2;
      FN_XOR:  value = in.rdata1 ^ op2;
      FN_SLL:  value = in.rdata1 << shamt;
      FN_SRL:  value = in.rdata1 >> shamt;
      FN_SLT:  value = {{(`EXEC_XLEN-1){1'b0}}, $signed(in.rdata1) < $signed(op2)};
      FN_SLTU: value = {{(`EXEC_XLEN-1){1'b0}}, in.rdata1 < op2};
      default: value = '0;
    endcase

    // Branches always compare the two register operands.
    case (in.fn.branch)
      FN_BEQ:  cond = (in.rdata1 == in.rdata2);
      FN_BNE:  cond = (in.rdata1 != in.rdata2);
      FN_BLT:  cond = ($signed(in.rdata1) < $signed(in.rdata2));
      FN_BGE:  cond = ($signed(in.rdata1) >= $signed(in.rdata2));
      FN_BLTU: cond = (in.rdata1 < in.rdata2);
      FN_BGEU: cond = (in.rdata1 >= in.rdata2);
      default: cond = 1'b0;
    endcase

    // Branches write no register, so their result word is zero.
    out.result = (in.unit == UNIT_ALU) ? value : '0;
    out.taken = (in.unit == UNIT_BRANCH) && cond;
    out.target = in.pc + in.imm;
  end

endmodule

// ==== verilog/div_counter.sv ====
`include "exec_params.svh"

module div_counter (
  input  logic clock,
  input  logic reset,
  input  logic load,
  input  logic step,
  output logic done_count
);

  localparam int CW = $clog2(`EXEC_DIV_STEPS);

  // Counts the steps still to go after the current one, so zero marks the last step.
  logic [CW-1:0] count;

  always_ff @(posedge clock) begin
    if (!reset) begin
      count <= '0;
    end else if (load) begin
      count <= CW'(`EXEC_DIV_STEPS - 1);
    end else if (step && count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign done_count = (count == '0);

endmodule

// ==== verilog/div_control.sv ====
module div_control import exec_pkg::*; (
  input  logic clock,
  input  logic reset,
  input  logic start,
  input  logic flush,
  input  logic mem_stall,
  input  logic done_count,
  output logic load,
  output logic step,
  output logic busy,
  output logic complete
);

  div_state_t state;
  div_state_t state_next;

  always_comb begin
    state_next = state;
    load = 1'b0;
    step = 1'b0;
    complete = 1'b0;

    case (state)
      DIV_IDLE: begin
        if (start) begin
          load = 1'b1;
          state_next = DIV_BUSY;
        end
      end
      DIV_BUSY: begin
        // Back-pressure freezes the iteration where it is.
        if (!mem_stall) begin
          step = 1'b1;
          if (done_count) begin
            state_next = DIV_DONE;
          end
        end
      end
      DIV_DONE: begin
        if (!mem_stall) begin
          complete = 1'b1;
          state_next = DIV_IDLE;
        end
      end
      default: state_next = DIV_IDLE;
    endcase

    if (flush) begin
      load = 1'b0;
      step = 1'b0;
      complete = 1'b0;
      state_next = DIV_IDLE;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= DIV_IDLE;
    end else begin
      state <= state_next;
    end
  end

  assign busy = (state != DIV_IDLE);

endmodule

// ==== verilog/div_datapath.sv ====
`include "exec_params.svh"

module div_datapath (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  load,
  input  logic                  step,
  input  logic [`EXEC_XLEN-1:0] dividend,
  input  logic [`EXEC_XLEN-1:0] divisor,
  output logic [`EXEC_XLEN-1:0] quotient,
  output logic [`EXEC_XLEN-1:0] remainder
);

  logic [`EXEC_XLEN-1:0] rem;
  logic [`EXEC_XLEN-1:0] quot;
  logic [`EXEC_XLEN-1:0] dsor;

  // Partial remainder with the next dividend bit shifted in, one bit wider.
  logic [`EXEC_XLEN:0] shifted;
  logic [`EXEC_XLEN:0] diff;
  logic                fits;

  always_comb begin
    shifted = {rem, quot[`EXEC_XLEN-1]};
    diff = shifted - {1'b0, dsor};
    // No borrow means the divisor goes in once at this position.
    fits = !diff[`EXEC_XLEN];
  end

  // The quotient register starts out holding the dividend and fills with
  // result bits from the right as the dividend bits leave on the left.
  // A zero divisor always fits, which leaves all ones in the quotient and
  // walks the whole dividend into the remainder.
  always_ff @(posedge clock) begin
    if (!reset) begin
      rem <= '0;
      quot <= '0;
      dsor <= '0;
    end else if (load) begin
      rem <= '0;
      quot <= dividend;
      dsor <= divisor;
    end else if (step) begin
      if (fits) begin
        rem <= diff[`EXEC_XLEN-1:0];
      end else begin
        rem <= shifted[`EXEC_XLEN-1:0];
      end
      quot <= {quot[`EXEC_XLEN-2:0], fits};
    end
  end

  assign quotient = quot;
  assign remainder = rem;

endmodule

// ==== verilog/execute_stage.sv ====
`include "exec_params.svh"

module execute_stage import exec_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  execute_in_t  d,
  input  logic         flush,
  input  logic         mem_stall,
  output execute_out_t q,
  output logic         stall
);

  alu_result_t           alu_out;
  execute_out_t          q_next;
  logic                  accept;
  logic                  start;
  logic                  load;
  logic                  step;
  logic                  busy;
  logic                  complete;
  logic                  done_count;
  logic [`EXEC_XLEN-1:0] quotient;
  logic [`EXEC_XLEN-1:0] remainder;
  logic [4:0]            div_rd;
  div_fn_t               div_fn;

  exec_alu alu (
    .in  (d),
    .out (alu_out)
  );

  div_control control (
    .clock      (clock),
    .reset      (reset),
    .start      (start),
    .flush      (flush),
    .mem_stall  (mem_stall),
    .done_count (done_count),
    .load       (load),
    .step       (step),
    .busy       (busy),
    .complete   (complete)
  );

  div_counter counter (
    .clock      (clock),
    .reset      (reset),
    .load       (load),
    .step       (step),
    .done_count (done_count)
  );

  div_datapath datapath (
    .clock     (clock),
    .reset     (reset),
    .load      (load),
    .step      (step),
    .dividend  (d.rdata1),
    .divisor   (d.rdata2),
    .quotient  (quotient),
    .remainder (remainder)
  );

  // A flush drops whatever decode presents, so it is never held.
  always_comb begin
    stall = !flush && (busy || mem_stall);
    accept = d.valid && !stall && !flush;
    start = accept && (d.unit == UNIT_DIV);
  end

  // The division keeps only its destination and function.
  // Its operands already sit in the datapath.
  always_ff @(posedge clock) begin
    if (start) begin
      div_rd <= d.rd;
      div_fn <= d.fn.div;
    end
  end

  always_comb begin
    q_next = q;
    if (flush) begin
      q_next.valid = 1'b0;
    end else if (!mem_stall) begin
      q_next.valid = 1'b0;
      if (complete) begin
        q_next.valid = 1'b1;
        q_next.rd = div_rd;
        q_next.wdata = (div_fn == FN_REMU) ? remainder : quotient;
        q_next.taken = 1'b0;
        q_next.target = '0;
      end else if (accept && d.unit != UNIT_DIV) begin
        q_next.valid = 1'b1;
        q_next.rd = d.rd;
        q_next.wdata = alu_out.result;
        q_next.taken = alu_out.taken;
        q_next.target = alu_out.target;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      q.valid <= 1'b0;
    end else begin
      q <= q_next;
    end
  end

endmodule

// ==== testbench/exec_checker.sv ====
`include "exec_params.svh"

module exec_checker import exec_pkg::*; (
  input logic         clock,
  input logic         reset,
  input logic         flush,
  input logic         mem_stall,
  input logic         stall,
  input execute_out_t q
);

  timeunit 1ns;
  timeprecision 100ps;

  string                 name_q[$];
  logic [4:0]            rd_q[$];
  logic [`EXEC_XLEN-1:0] wdata_q[$];
  logic                  taken_q[$];
  logic [`EXEC_XLEN-1:0] target_q[$];

  int           value_errors = 0;
  int           protocol_errors = 0;
  execute_out_t held_q;
  logic         holding = 1'b0;

  task automatic expect_result(input string name, input logic [4:0] rd,
                               input logic [`EXEC_XLEN-1:0] wdata, input logic taken,
                               input logic [`EXEC_XLEN-1:0] target);
    name_q.push_back(name);
    rd_q.push_back(rd);
    wdata_q.push_back(wdata);
    taken_q.push_back(taken);
    target_q.push_back(target);
  endtask

  function automatic int pending_count();
    return name_q.size();
  endfunction

  task automatic compare_field(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s %s expected %h actual %h", name, field, expected, actual);
      value_errors++;
    end
  endtask

  // The memory stage takes q on every edge where it is valid and not stalling.
  always @(posedge clock) begin : watch
    string name;
    if (reset) begin
      if (holding && q !== held_q) begin
        $display("The output register changed while the memory stage was stalling");
        protocol_errors++;
      end
      if (mem_stall && !flush && stall !== 1'b1) begin
        $display("stall was low while the memory stage was stalling");
        protocol_errors++;
      end
      if (q.valid === 1'b1 && !mem_stall) begin
        if (name_q.size() == 0) begin
          $display("Unexpected result for rd %0d with wdata %h", q.rd, q.wdata);
          protocol_errors++;
        end else begin
          name = name_q.pop_front();
          compare_field(name, "rd", {27'b0, rd_q.pop_front()}, {27'b0, q.rd});
          compare_field(name, "wdata", wdata_q.pop_front(), q.wdata);
          compare_field(name, "taken", {31'b0, taken_q.pop_front()}, {31'b0, q.taken});
          compare_field(name, "target", target_q.pop_front(), q.target);
        end
      end
      holding = mem_stall && !flush && (q.valid === 1'b1);
      held_q = q;
    end else begin
      holding = 1'b0;
    end
  end

endmodule

// ==== testbench/tb_execute_stage.sv ====
`include "exec_params.svh"

module tb_execute_stage import exec_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int PERIOD = 40;
  localparam int WAIT_LIMIT = 200;

  logic          clock;
  logic          reset;
  logic          flush;
  logic          mem_stall;
  logic          stall;
  execute_in_t   d;
  execute_out_t  q;
  logic [31:0]   field [11];
  integer        seed = 32'h9045;
  int            stim_errors = 0;
  bit            aborted = 1'b0;

  execute_stage dut (
    .clock     (clock),
    .reset     (reset),
    .d         (d),
    .flush     (flush),
    .mem_stall (mem_stall),
    .q         (q),
    .stall     (stall)
  );

  exec_checker check (
    .clock     (clock),
    .reset     (reset),
    .flush     (flush),
    .mem_stall (mem_stall),
    .stall     (stall),
    .q         (q)
  );

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  task automatic note_problem(input string what);
    $display("%s", what);
    stim_errors++;
  endtask

  // Holds the instruction on d, with mem_stall high for the first bubble cycles,
  // until an edge where stall is low accepts it.
  task automatic present(input string name, input execute_in_t instr, input int bubble,
                         output bit accepted);
    int waited;
    waited = 0;
    accepted = 1'b0;
    @(negedge clock);
    d = instr;
    mem_stall = (bubble > 0);
    while (!accepted && !aborted) begin
      #(PERIOD / 4);
      accepted = !stall;
      @(posedge clock);
      waited++;
      if (!accepted && waited >= WAIT_LIMIT) begin
        note_problem($sformatf("Timeout waiting for %s to be accepted", name));
        aborted = 1'b1;
      end else if (!accepted) begin
        @(negedge clock);
        mem_stall = (waited < bubble);
      end
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    @(negedge clock);
    d.valid = 1'b0;
    mem_stall = 1'b0;
    while (check.pending_count() > 0 && !aborted) begin
      @(negedge clock);
      waited++;
      if (waited >= WAIT_LIMIT) begin
        note_problem($sformatf("Timeout with %0d results missing", check.pending_count()));
        aborted = 1'b1;
      end
    end
  endtask

  // A division is accepted and then flushed while it runs; anything else
  // is flushed on the edge that would have accepted it.
  task automatic flush_instruction(input string name, input execute_in_t instr);
    bit accepted;
    int i;
    drain();
    if (instr.unit == UNIT_DIV && !aborted) begin
      present(name, instr, 0, accepted);
      @(negedge clock);
      d.valid = 1'b0;
      for (i = 0; i < 3; i++) begin
        @(negedge clock);
      end
    end else begin
      @(negedge clock);
      d = instr;
    end
    flush = 1'b1;
    #(PERIOD / 4);
    if (stall !== 1'b0) begin
      note_problem($sformatf("stall stayed high during the flush of %s", name));
    end
    @(negedge clock);
    d.valid = 1'b0;
    flush = 1'b0;
    #(PERIOD / 4);
    if (stall !== 1'b0) begin
      note_problem($sformatf("The stage was still stalled after the flush of %s", name));
    end
  endtask

  task automatic run_test(input string name, input int index);
    execute_in_t instr;
    bit          accepted;
    int          bubble;
    instr = '0;
    instr.valid = 1'b1;
    instr.unit = unit_t'(field[0][1:0]);
    case (instr.unit)
      UNIT_BRANCH: instr.fn.branch = branch_fn_t'(field[1][3:0]);
      UNIT_DIV:    instr.fn.div = div_fn_t'(field[1][3:0]);
      default:     instr.fn.alu = alu_fn_t'(field[1][3:0]);
    endcase
    instr.rdata1 = field[2];
    instr.rdata2 = field[3];
    instr.imm = field[4];
    instr.sel_imm = field[5][0];
    instr.pc = field[6];
    instr.rd = 5'(index % 31 + 1);
    if (field[7] != 0) begin
      flush_instruction(name, instr);
    end else begin
      bubble = $unsigned($random(seed)) % 4;
      present(name, instr, bubble, accepted);
      if (accepted) begin
        check.expect_result(name, instr.rd, field[8], field[9][0], field[10]);
        if (instr.unit == UNIT_DIV) begin
          #(PERIOD / 4);
          if (stall !== 1'b1) begin
            note_problem($sformatf("stall was low while %s was running", name));
          end
        end
      end
    end
  endtask

  initial begin
    string line;
    string name;
    int    fd;
    int    fields;
    int    index;
    int    i;
    reset = 1'b0;
    flush = 1'b0;
    mem_stall = 1'b0;
    d = '0;
    index = 0;
    for (i = 0; i < 3; i++) begin
      @(posedge clock);
    end
    @(negedge clock);
    reset = 1'b1;
    #(PERIOD / 4);
    if (q.valid !== 1'b0 || stall !== 1'b0) begin
      note_problem("q.valid or stall was not low after reset");
    end

    fd = $fopen("testbench/execute_tests.txt", "r");
    if (fd == 0) begin
      note_problem("Cannot open testbench/execute_tests.txt");
      aborted = 1'b1;
    end
    while (!aborted && !$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", name, field[0],
                         field[1], field[2], field[3], field[4], field[5], field[6],
                         field[7], field[8], field[9], field[10]);
        if (fields == 12) begin
          run_test(name, index);
          index++;
        end else begin
          note_problem($sformatf("Malformed test line: %s", line));
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    if (!aborted) begin
      drain();
    end
    // A few idle cycles show any result that turns up with nothing outstanding.
    for (i = 0; i < 5; i++) begin
      @(negedge clock);
    end
    $display("Errors: %0d wrong values, %0d protocol, %0d stimulus",
             check.value_errors, check.protocol_errors, stim_errors);
    if (check.value_errors + check.protocol_errors + stim_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+verilog
verilog/exec_pkg.sv
verilog/exec_alu.sv
verilog/div_counter.sv
verilog/div_control.sv
verilog/div_datapath.sv
verilog/execute_stage.sv
testbench/exec_checker.sv
testbench/tb_execute_stage.sv

// ==== testbench/execute_tests.txt ====
# name unit fn rdata1 rdata2 imm sel_imm pc flush exp_wdata exp_taken exp_target (hex)
# unit 0 alu, 1 branch, 2 div; fn is the function code within that unit
add_reg 0 0 00000005 00000007 00000010 0 00001000 0 0000000c 0 00001010
add_imm 0 0 00000005 00000007 fffffffc 1 00001004 0 00000001 0 00001000
sub_reg 0 1 00000003 00000005 00000000 0 00001008 0 fffffffe 0 00001008
and_imm 0 2 f0f0ff00 12345678 0000ff0f 1 0000100c 0 0000ff00 0 00010f1b
or_reg 0 3 a5a50000 00005a5a 00000000 0 00001010 0 a5a55a5a 0 00001010
xor_reg 0 4 ffff0000 0f0f0f0f 00000004 0 00001014 0 f0f00f0f 0 00001018
sll_imm 0 5 00000001 00000000 0000001f 1 00001018 0 80000000 0 00001037
sll_reg 0 5 00000003 00000024 00000000 0 0000101c 0 00000030 0 0000101c
srl_imm 0 6 80000000 00000000 00000004 1 00001020 0 08000000 0 00001024
slt_reg 0 7 ffffffff 00000001 00000000 0 00001024 0 00000001 0 00001024
sltu_reg 0 8 ffffffff 00000001 00000000 0 00001028 0 00000000 0 00001028
slt_imm 0 7 00000005 00000000 fffffff0 1 0000102c 0 00000000 0 0000101c
beq_taken 1 0 00000042 00000042 00000100 0 00002000 0 00000000 1 00002100
bne_not 1 1 00000042 00000042 00000010 0 00002004 0 00000000 0 00002014
blt_taken 1 2 fffffff0 00000001 fffffff8 0 00002008 0 00000000 1 00002000
bge_taken 1 3 00000001 fffffff0 00000020 0 0000200c 0 00000000 1 0000202c
bltu_not 1 4 fffffff0 00000001 00000040 0 00002010 0 00000000 0 00002050
bgeu_taken 1 5 fffffff0 00000001 00000008 1 00002014 0 00000000 1 0000201c
divu_basic 2 0 00000064 00000007 00000000 0 00003000 0 0000000e 0 00000000
remu_basic 2 1 00000064 00000007 00000000 0 00003004 0 00000002 0 00000000
divu_big 2 0 ffffffff 00000010 00000000 0 00003008 0 0fffffff 0 00000000
remu_big 2 1 ffffffff 00000010 00000000 0 0000300c 0 0000000f 0 00000000
divu_zero 2 0 12345678 00000000 00000000 0 00003010 0 ffffffff 0 00000000
remu_zero 2 1 12345678 00000000 00000000 0 00003014 0 12345678 0 00000000
divu_hi 2 0 80000001 80000000 00000000 0 00003018 0 00000001 0 00000000
flush_add 0 0 00000001 00000001 00000000 0 00004000 1 00000000 0 00000000
add_after_flush 0 0 00000010 00000020 00000000 0 00004000 0 00000030 0 00004000
flush_divu 2 0 00001000 00000003 00000000 0 00004004 1 00000000 0 00000000
divu_after_flush 2 0 00001000 00000003 00000000 0 00004004 0 00000555 0 00000000
remu_after_flush 2 1 00001000 00000003 00000000 0 00004008 0 00000001 0 00000000
sub_after_div 0 1 00000000 00000001 00000000 0 0000400c 0 ffffffff 0 0000400c
